/* vga_pkg.sv */
package vga_pkg;

   typedef logic signed [10:0] coord_t;      // raster spot coordinate

   typedef struct packed {
      logic [7:0] r;                         // red
      logic [7:0] g;                         // green
      logic [7:0] b;                         // blue
   } rgb_t;

   typedef logic [9:0] dac_t;                // one video dac channel

   // 640x480 raster, counted in pixels and lines
   localparam int DEF_H_ACTIVE = 640;        // visible pixels per line
   localparam int DEF_H_FRONT  = 16;         // pixels before hsync
   localparam int DEF_H_SYNC   = 96;         // hsync width
   localparam int DEF_H_BACK   = 48;         // pixels after hsync
   localparam int DEF_V_ACTIVE = 480;        // visible lines per frame
   localparam int DEF_V_FRONT  = 10;         // lines before vsync
   localparam int DEF_V_SYNC   = 2;          // vsync width in lines
   localparam int DEF_V_BACK   = 33;         // lines after vsync

   localparam int PIPE_DELAY = 2;            // spot to colour latency

   // 8-bit channel onto the 10-bit dac
   function automatic dac_t to_dac(input logic [7:0] c);
      return {c, 2'b00};                     // low bits stay zero
   endfunction

endpackage

/* game_pkg.sv */
package game_pkg;

   import vga_pkg::*;

   // direction opcode decoded from the buttons
   typedef enum logic [2:0] {
      DIR_NONE  = 3'd0,                      // no button held
      DIR_UP    = 3'd1,
      DIR_DOWN  = 3'd2,
      DIR_LEFT  = 3'd3,
      DIR_RIGHT = 3'd4
   } dir_e;

   typedef logic [9:0] pos_t;                // token top-left corner

   // token colours, both with nonzero green
   localparam rgb_t P1_RGB = '{r: 8'hf0, g: 8'hc8, b: 8'h10};   // yellow
   localparam rgb_t P2_RGB = '{r: 8'h20, g: 8'he0, b: 8'h30};   // green

   localparam logic [7:0] BG_BLUE = 8'h60;   // constant blue of the backdrop

endpackage

/* pixel_if.sv */
`timescale 1ns/1ps

interface pixel_if import vga_pkg::*; ();

   coord_t spot_x;                           // column, 0 = first active pixel
   coord_t spot_y;                           // line, 0 = first active line
   logic   active;                           // spot inside visible area
   logic   frame_end;                        // pulse right after last visible pixel

   // timing generator side
   modport src  (output spot_x, output spot_y, output active, output frame_end);
   // players only care about frame boundaries
   modport ctrl (input frame_end);
   // per-pixel consumers
   modport pix  (input spot_x, input spot_y, input active);

endinterface

/* vga_sync.sv */
`timescale 1ns/1ps

module vga_sync import vga_pkg::*; #(
   parameter int H_ACTIVE = DEF_H_ACTIVE,
   parameter int H_FRONT  = DEF_H_FRONT,
   parameter int H_SYNC   = DEF_H_SYNC,
   parameter int H_BACK   = DEF_H_BACK,
   parameter int V_ACTIVE = DEF_V_ACTIVE,
   parameter int V_FRONT  = DEF_V_FRONT,
   parameter int V_SYNC   = DEF_V_SYNC,
   parameter int V_BACK   = DEF_V_BACK
) (
   input  logic clk,
   input  logic rst_n,
   pixel_if.src px,
   output logic hs,                          // active low
   output logic vs,                          // active low
   output logic blank                        // high on visible pixels
);

   // counter limits, active area first so zero is the top-left pixel
   localparam logic [10:0] H_LAST   = 11'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);
   localparam logic [10:0] V_LAST   = 11'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);
   localparam logic [10:0] H_VIS    = 11'(H_ACTIVE);
   localparam logic [10:0] V_VIS    = 11'(V_ACTIVE);
   localparam logic [10:0] HS_START = 11'(H_ACTIVE + H_FRONT);
   localparam logic [10:0] HS_STOP  = 11'(H_ACTIVE + H_FRONT + H_SYNC);
   localparam logic [10:0] VS_START = 11'(V_ACTIVE + V_FRONT);
   localparam logic [10:0] VS_STOP  = 11'(V_ACTIVE + V_FRONT + V_SYNC);

   logic [10:0]           h_cnt;             // pixel in line
   logic [10:0]           v_cnt;             // line in frame
   logic                  line_end;
   logic                  hs_raw;
   logic                  vs_raw;
   logic [PIPE_DELAY-1:0] hs_dly;            // sync and blank delay taps
   logic [PIPE_DELAY-1:0] vs_dly;
   logic [PIPE_DELAY-1:0] blank_dly;

   assign line_end = (h_cnt == H_LAST);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else if (line_end) begin
         h_cnt <= '0;                        // wrap to next line
         if (v_cnt == V_LAST) begin
            v_cnt <= '0;                     // new frame
         end else begin
            v_cnt <= v_cnt + 11'd1;
         end
      end else begin
         h_cnt <= h_cnt + 11'd1;
      end
   end

   assign px.spot_x    = coord_t'(h_cnt);
   assign px.spot_y    = coord_t'(v_cnt);
   assign px.active    = (h_cnt < H_VIS) && (v_cnt < V_VIS);
   assign px.frame_end = (h_cnt == H_VIS) && (v_cnt == V_VIS - 11'd1);   // just past last pixel

   assign hs_raw = !((h_cnt >= HS_START) && (h_cnt < HS_STOP));
   assign vs_raw = !((v_cnt >= VS_START) && (v_cnt < VS_STOP));   // whole lines

   // delay syncs to meet the colour coming out of the mixer
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         hs_dly    <= '1;                    // idle high
         vs_dly    <= '1;
         blank_dly <= '0;
      end else begin
         hs_dly    <= {hs_dly[PIPE_DELAY-2:0], hs_raw};
         vs_dly    <= {vs_dly[PIPE_DELAY-2:0], vs_raw};
         blank_dly <= {blank_dly[PIPE_DELAY-2:0], px.active};
      end
   end

   assign hs    = hs_dly[PIPE_DELAY-1];
   assign vs    = vs_dly[PIPE_DELAY-1];
   assign blank = blank_dly[PIPE_DELAY-1];

endmodule

/* player_ctrl.sv */
`timescale 1ns/1ps

module player_ctrl import game_pkg::*; #(
   parameter int X0          = 0,
   parameter int Y0          = 0,
   parameter int STEP        = 4,
   parameter int SPRITE_SIZE = 32,
   parameter int H_ACTIVE    = 640,
   parameter int V_ACTIVE    = 480
) (
   input  logic  clk,
   input  logic  rst_n,
   pixel_if.ctrl px,
   input  logic  up,
   input  logic  down,
   input  logic  left,
   input  logic  right,
   output pos_t  pos_x,
   output pos_t  pos_y
);

   localparam int X_MAX = H_ACTIVE - SPRITE_SIZE;   // rightmost legal corner
   localparam int Y_MAX = V_ACTIVE - SPRITE_SIZE;   // lowest legal corner

   dir_e dir;
   pos_t nxt_x;
   pos_t nxt_y;

   // button priority up > down > left > right
   always_comb begin
      if (up) begin
         dir = DIR_UP;
      end else if (down) begin
         dir = DIR_DOWN;
      end else if (left) begin
         dir = DIR_LEFT;
      end else if (right) begin
         dir = DIR_RIGHT;
      end else begin
         dir = DIR_NONE;
      end
   end

   // one step, clamped so the whole token stays visible
   always_comb begin
      nxt_x = pos_x;
      nxt_y = pos_y;
      case (dir)
         DIR_UP:    nxt_y = (int'(pos_y) < STEP) ? '0 : pos_y - pos_t'(STEP);
         DIR_DOWN:  nxt_y = (int'(pos_y) + STEP > Y_MAX) ? pos_t'(Y_MAX) : pos_y + pos_t'(STEP);
         DIR_LEFT:  nxt_x = (int'(pos_x) < STEP) ? '0 : pos_x - pos_t'(STEP);
         DIR_RIGHT: nxt_x = (int'(pos_x) + STEP > X_MAX) ? pos_t'(X_MAX) : pos_x + pos_t'(STEP);
         default:   ;                        // DIR_NONE holds position
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pos_x <= pos_t'(X0);
         pos_y <= pos_t'(Y0);
      end else if (px.frame_end) begin       // only between frames, no tearing
         pos_x <= nxt_x;
         pos_y <= nxt_y;
      end
   end

endmodule

/* sprite_render.sv */
`timescale 1ns/1ps

module sprite_render import vga_pkg::*, game_pkg::*; #(
   parameter int SPRITE_SIZE = 32
) (
   input  logic clk,
   pixel_if.pix px,
   input  pos_t p1_x,
   input  pos_t p1_y,
   input  pos_t p2_x,
   input  pos_t p2_y,
   output logic p1_hit,                      // token 1 covers spot, one cycle late
   output logic p2_hit                       // token 2 covers spot, one cycle late
);

   logic p1_in;
   logic p2_in;

   // spot inside the square starting at the token corner
   function automatic logic covers(input coord_t sx, input coord_t sy,
                                   input pos_t cx, input pos_t cy);
      coord_t dx;
      coord_t dy;
      dx = sx - coord_t'(cx);                // offset from corner
      dy = sy - coord_t'(cy);
      return (dx >= 0) && (dx < SPRITE_SIZE) && (dy >= 0) && (dy < SPRITE_SIZE);
   endfunction

   assign p1_in = px.active && covers(px.spot_x, px.spot_y, p1_x, p1_y);
   assign p2_in = px.active && covers(px.spot_x, px.spot_y, p2_x, p2_y);

   always_ff @(posedge clk) begin
      p1_hit <= p1_in;                       // first pipe stage
      p2_hit <= p2_in;
   end

endmodule

/* pixel_mixer.sv */
`timescale 1ns/1ps

module pixel_mixer import vga_pkg::*, game_pkg::*; (
   input  logic clk,
   input  logic rst_n,
   pixel_if.pix px,
   input  logic p1_hit,
   input  logic p2_hit,
   output dac_t vga_r,
   output dac_t vga_g,
   output dac_t vga_b
);

   logic [7:0] x_d;                          // low spot_x bits aligned with hits
   logic       active_d;                     // active aligned with hits
   rgb_t       bg;
   rgb_t       pix;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         active_d <= 1'b0;
      end else begin
         active_d <= px.active;
      end
   end

   always_ff @(posedge clk) begin
      x_d <= px.spot_x[7:0];
   end

   // red ramp along the line over flat blue
   assign bg = '{r: x_d, g: 8'h00, b: BG_BLUE};

   // player 1 drawn on top of player 2
   always_comb begin
      if (p1_hit) begin
         pix = P1_RGB;
      end else if (p2_hit) begin
         pix = P2_RGB;
      end else begin
         pix = bg;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n || !active_d) begin         // black outside visible area
         vga_r <= '0;
         vga_g <= '0;
         vga_b <= '0;
      end else begin
         vga_r <= to_dac(pix.r);
         vga_g <= to_dac(pix.g);
         vga_b <= to_dac(pix.b);
      end
   end

endmodule

/* bomber_display.sv */
`timescale 1ns/1ps

module bomber_display import vga_pkg::*, game_pkg::*; #(
   parameter int H_ACTIVE    = DEF_H_ACTIVE,
   parameter int H_FRONT     = DEF_H_FRONT,
   parameter int H_SYNC      = DEF_H_SYNC,
   parameter int H_BACK      = DEF_H_BACK,
   parameter int V_ACTIVE    = DEF_V_ACTIVE,
   parameter int V_FRONT     = DEF_V_FRONT,
   parameter int V_SYNC      = DEF_V_SYNC,
   parameter int V_BACK      = DEF_V_BACK,
   parameter int SPRITE_SIZE = 32,           // token edge
   parameter int STEP        = 4,            // pixels per frame
   parameter int P1_X0       = 40,           // player 1 start corner
   parameter int P1_Y0       = 40,
   parameter int P2_X0       = 568,          // player 2 start corner
   parameter int P2_Y0       = 408
) (
   input  logic clk,
   input  logic rst_n,
   input  logic j1_up, j1_down, j1_left, j1_right,
   input  logic j2_up, j2_down, j2_left, j2_right,
   output logic vga_hs,
   output logic vga_vs,
   output logic vga_blank,
   output dac_t vga_r,
   output dac_t vga_g,
   output dac_t vga_b
);

   pos_t p1_x, p1_y, p2_x, p2_y;             // token corners
   logic p1_hit, p2_hit;

   pixel_if pix_bus ();                      // raster position bus

   vga_sync #(.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
              .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK))
      u_sync (.clk(clk), .rst_n(rst_n), .px(pix_bus.src),
              .hs(vga_hs), .vs(vga_vs), .blank(vga_blank));

   player_ctrl #(.X0(P1_X0), .Y0(P1_Y0), .STEP(STEP), .SPRITE_SIZE(SPRITE_SIZE),
                 .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE))
      u_p1 (.clk(clk), .rst_n(rst_n), .px(pix_bus.ctrl), .up(j1_up), .down(j1_down),
            .left(j1_left), .right(j1_right), .pos_x(p1_x), .pos_y(p1_y));

   player_ctrl #(.X0(P2_X0), .Y0(P2_Y0), .STEP(STEP), .SPRITE_SIZE(SPRITE_SIZE),
                 .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE))
      u_p2 (.clk(clk), .rst_n(rst_n), .px(pix_bus.ctrl), .up(j2_up), .down(j2_down),
            .left(j2_left), .right(j2_right), .pos_x(p2_x), .pos_y(p2_y));

   sprite_render #(.SPRITE_SIZE(SPRITE_SIZE))
      u_sprite (.clk(clk), .px(pix_bus.pix), .p1_x(p1_x), .p1_y(p1_y), .p2_x(p2_x),
                .p2_y(p2_y), .p1_hit(p1_hit), .p2_hit(p2_hit));

   pixel_mixer u_mix (.clk(clk), .rst_n(rst_n), .px(pix_bus.pix), .p1_hit(p1_hit),
                      .p2_hit(p2_hit), .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b));

endmodule

/* tb_bomber_display.sv */
`timescale 1ns/1ps

module tb_bomber_display import vga_pkg::*, game_pkg::*; ();

   localparam int H_ACT = 16;
   localparam int V_ACT = 12;
   localparam int H_TOT = 16 + 2 + 3 + 3;
   localparam int V_TOT = 12 + 1 + 2 + 1;
   localparam int SZ    = 3;
   localparam int STP   = 2;
   localparam int NPIX  = H_ACT * V_ACT;
   localparam int NFIX  = 6;                 // hand-computed rows
   localparam int NROW  = NFIX + 4;          // plus random rows

   logic clk = 1'b0;
   logic rst_n;
   logic [7:0] btn;                          // {j1 u d l r, j2 u d l r}
   logic vga_hs, vga_vs, vga_blank;
   dac_t vga_r, vga_g, vga_b;

   typedef struct {
      logic [7:0] btn;
      int         frames;
      int         e1x, e1y, e2x, e2y;        // -1 means use the model
   } row_t;

   row_t row_tab [NROW];
   dac_t got_r [NPIX];
   dac_t got_g [NPIX];
   dac_t got_b [NPIX];
   int   errors = 0;
   int   failed = 0;
   int   m1x = 1, m1y = 1, m2x = 12, m2y = 8;   // model corners
   bit   table_ready = 0;

   // frame statistics, latched at each vs fall
   int   c_blank = 0, c_hs = 0, c_vs = 0, c_lines = 0, c_bad = 0, run_len = 0;
   int   l_blank, l_hs, l_vs, l_lines, l_bad;
   logic prev_vs = 1'b1, prev_blank = 1'b0;

   bomber_display #(
      .H_ACTIVE(16), .H_FRONT(2), .H_SYNC(3), .H_BACK(3),
      .V_ACTIVE(12), .V_FRONT(1), .V_SYNC(2), .V_BACK(1),
      .SPRITE_SIZE(SZ), .STEP(STP),
      .P1_X0(1), .P1_Y0(1), .P2_X0(12), .P2_Y0(8)
   ) uut (
      .clk(clk), .rst_n(rst_n),
      .j1_up(btn[7]), .j1_down(btn[6]), .j1_left(btn[5]), .j1_right(btn[4]),
      .j2_up(btn[3]), .j2_down(btn[2]), .j2_left(btn[1]), .j2_right(btn[0]),
      .vga_hs(vga_hs), .vga_vs(vga_vs), .vga_blank(vga_blank),
      .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b)
   );

   always #20 clk = ~clk;                    // 40 ns period

   always @(negedge clk) begin
      if (rst_n) begin
         if (prev_vs && !vga_vs) begin       // frame boundary
            l_blank = c_blank; l_hs = c_hs; l_vs = c_vs; l_lines = c_lines; l_bad = c_bad;
            c_blank = 0; c_hs = 0; c_vs = 0; c_lines = 0; c_bad = 0;
         end
         if (vga_blank) begin
            c_blank++;
            run_len++;
         end else if (prev_blank) begin      // end of a visible line
            c_lines++;
            if (run_len != H_ACT) c_bad++;
            run_len = 0;
         end
         if (!vga_hs) c_hs++;
         if (!vga_vs) c_vs++;
         prev_vs    = vga_vs;
         prev_blank = vga_blank;
      end
   end

   task automatic check_dac(input string name, input dac_t got, input dac_t exp);
      if (got !== exp) begin
         $display("MISMATCH %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_pos(input string name, input pos_t got, input pos_t exp);
      if (got !== exp) begin
         $display("MISMATCH %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_int(input string name, input int got, input int exp);
      if (got != exp) begin
         $display("MISMATCH %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   // one frame step for a single axis pair, priority up down left right
   task automatic move(input logic [3:0] b, inout int x, inout int y);
      if (b[3]) y = (y < STP) ? 0 : y - STP;
      else if (b[2]) y = (y + STP > V_ACT - SZ) ? V_ACT - SZ : y + STP;
      else if (b[1]) x = (x < STP) ? 0 : x - STP;
      else if (b[0]) x = (x + STP > H_ACT - SZ) ? H_ACT - SZ : x + STP;
   endtask

   function automatic bit inside_tok(input int px, input int py, input int cx, input int cy);
      return px >= cx && px < cx + SZ && py >= cy && py < cy + SZ;
   endfunction

   task automatic scan_frame();
      int n;
      n = 0;
      while (n < NPIX) begin
         @(negedge clk);
         if (vga_blank) begin
            got_r[n] = vga_r;
            got_g[n] = vga_g;
            got_b[n] = vga_b;
            n++;
         end else begin
            // channels must be dark outside the visible area
            check_dac("vga_r (blank low)", vga_r, '0);
            check_dac("vga_g (blank low)", vga_g, '0);
            check_dac("vga_b (blank low)", vga_b, '0);
         end
      end
   endtask

   // full image against the model, then token corners from the scan
   task automatic check_frame(input int e1x, input int e1y, input int e2x, input int e2y);
      int   bad;
      int   f1, f2;
      dac_t er, eg, eb;
      bad = 0;
      f1  = -1;
      f2  = -1;
      for (int i = 0; i < NPIX; i++) begin
         if (inside_tok(i % H_ACT, i / H_ACT, m1x, m1y)) begin
            er = {P1_RGB.r, 2'b00}; eg = {P1_RGB.g, 2'b00}; eb = {P1_RGB.b, 2'b00};
         end else if (inside_tok(i % H_ACT, i / H_ACT, m2x, m2y)) begin
            er = {P2_RGB.r, 2'b00}; eg = {P2_RGB.g, 2'b00}; eb = {P2_RGB.b, 2'b00};
         end else begin
            er = dac_t'(i % H_ACT) << 2; eg = '0; eb = {BG_BLUE, 2'b00};
         end
         if (got_r[i] !== er || got_g[i] !== eg || got_b[i] !== eb) begin
            if (bad == 0) begin              // first bad pixel in detail
               $display("pixel x=%0d y=%0d differs", i % H_ACT, i / H_ACT);
               check_dac("vga_r", got_r[i], er);
               check_dac("vga_g", got_g[i], eg);
               check_dac("vga_b", got_b[i], eb);
            end
            bad++;
         end
         if (f1 < 0 && got_r[i] == {P1_RGB.r, 2'b00} && got_g[i] == {P1_RGB.g, 2'b00}
             && got_b[i] == {P1_RGB.b, 2'b00}) f1 = i;
         if (f2 < 0 && got_r[i] == {P2_RGB.r, 2'b00} && got_g[i] == {P2_RGB.g, 2'b00}
             && got_b[i] == {P2_RGB.b, 2'b00}) f2 = i;
      end
      check_int("bad_pixels", bad, 0);
      if (f1 < 0) begin
         $display("player 1 token not found in frame");
         errors++;
      end else begin
         check_pos("p1_x", pos_t'(f1 % H_ACT), pos_t'(e1x));
         check_pos("p1_y", pos_t'(f1 / H_ACT), pos_t'(e1y));
      end
      if (!inside_tok(e2x, e2y, e1x, e1y)) begin   // corner visible only if not covered
         if (f2 < 0) begin
            $display("player 2 token not found in frame");
            errors++;
         end else begin
            check_pos("p2_x", pos_t'(f2 % H_ACT), pos_t'(e2x));
            check_pos("p2_y", pos_t'(f2 / H_ACT), pos_t'(e2y));
         end
      end
   endtask

   initial begin
      int total_frames;
      void'($urandom(32'h1cdb_628e));
      row_tab[0] = '{8'b0000_0000, 1, 1, 1, 12, 8};   // reset corners
      row_tab[1] = '{8'b0001_0010, 3, 7, 1, 6, 8};    // p1 right, p2 left
      row_tab[2] = '{8'b0101_1000, 2, 7, 5, 6, 4};    // down beats right, overlap
      row_tab[3] = '{8'b0010_0001, 5, 0, 5, 13, 4};   // clamp left and right
      row_tab[4] = '{8'b1000_0100, 4, 0, 0, 13, 9};   // clamp top and bottom
      row_tab[5] = '{8'b1111_1111, 1, 0, 0, 13, 7};   // up wins
      for (int i = NFIX; i < NROW; i++) begin
         row_tab[i] = '{8'($urandom), 1 + int'($urandom % 3), -1, -1, -1, -1};
      end
      total_frames = 4;
      foreach (row_tab[i]) total_frames += row_tab[i].frames + 2;
      table_ready = 1;
      #(total_frames * H_TOT * V_TOT * 40 + 20000);
      $display("timeout after %0d frames worth of cycles", total_frames);
      $display("Some tests failed");
      $finish;
   end

   initial begin
      int e0;
      int e1x, e1y, e2x, e2y;
      rst_n = 1'b0;
      btn   = '0;
      wait (table_ready);
      @(negedge clk);
      check_dac("vga_r", vga_r, '0);         // outputs idle in reset
      check_dac("vga_g", vga_g, '0);
      check_dac("vga_b", vga_b, '0);
      check_int("vga_hs", vga_hs, 1);
      check_int("vga_vs", vga_vs, 1);
      check_int("vga_blank", vga_blank, 0);
      @(posedge clk);
      #2 rst_n = 1'b1;
      @(negedge vga_vs);
      for (int t = 0; t < NROW; t++) begin
         e0 = errors;
         @(posedge clk);
         #2 btn = row_tab[t].btn;
         repeat (row_tab[t].frames) begin
            @(negedge vga_vs);
            move(row_tab[t].btn[7:4], m1x, m1y);
            move(row_tab[t].btn[3:0], m2x, m2y);
         end
         @(posedge clk);
         #2 btn = '0;                        // no move during the scanned frame
         scan_frame();
         if (row_tab[t].e1x < 0) begin
            e1x = m1x; e1y = m1y; e2x = m2x; e2y = m2y;
         end else begin
            e1x = row_tab[t].e1x; e1y = row_tab[t].e1y;
            e2x = row_tab[t].e2x; e2y = row_tab[t].e2y;
         end
         check_frame(e1x, e1y, e2x, e2y);
         @(negedge vga_vs);
         @(negedge clk);
         #1;
         check_int("blank_cycles", l_blank, NPIX);
         check_int("lines", l_lines, V_ACT);
         check_int("short_lines", l_bad, 0);
         check_int("hs_low_cycles", l_hs, 3 * V_TOT);
         check_int("vs_low_cycles", l_vs, 2 * H_TOT);
         if (errors == e0) begin
            $display("test %0d buttons %b frames %0d ok", t, row_tab[t].btn, row_tab[t].frames);
         end else begin
            $display("test %0d buttons %b failed with %0d errors", t, row_tab[t].btn,
                     errors - e0);
            failed++;
         end
      end
      $display("tests %0d, failed %0d, errors %0d", NROW, failed, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

/* bomber_display.f */
vga_pkg.sv
game_pkg.sv
pixel_if.sv
vga_sync.sv
player_ctrl.sv
sprite_render.sv
pixel_mixer.sv
bomber_display.sv
tb_bomber_display.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_bomber_display
RTL_TOP   ?= bomber_display
FILELIST  ?= bomber_display.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed"

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(RTL_TOP) \
		vga_pkg.sv game_pkg.sv pixel_if.sv vga_sync.sv player_ctrl.sv \
		sprite_render.sv pixel_mixer.sv bomber_display.sv

clean:
	rm -rf $(OBJ_DIR)
